//--- bridge_cases.txt
# mode(0 serial, 1 paired) in_side kind(0 data, 1 ctrl) code addr data expected_out_side
# codes are 0 reset, 1 enumerate, 2 manager request, 3 manager response; all values hex
0 0 0 0 00000100 00000001 0
0 1 0 0 80000000 00000002 0
0 0 1 1 00001000 00000003 0
0 0 1 2 00000000 00000004 1
0 1 1 2 00000000 00000005 0
0 1 1 1 00002000 00000006 0
0 0 0 0 00001800 00000007 1
0 1 0 0 00001000 00000008 1
0 0 0 0 00002000 00000009 0
0 1 0 0 00000fff 0000000a 0
0 0 1 3 00000000 0000000b 0
0 1 1 3 00000000 0000000c 0
0 0 1 0 00001500 0000000d 1
0 1 1 1 00001400 0000000e 1
0 0 0 0 00001300 0000000f 0
0 1 0 0 00001400 00000010 1
0 1 1 3 00001900 00000011 1
0 1 1 2 00000000 00000012 0
0 1 1 3 00000000 00000013 1
0 0 1 3 00000000 00000014 1
1 0 0 0 00001500 0000a001 1
1 1 0 0 00000000 0000a002 0
1 0 0 0 00000100 0000a003 0
1 1 0 0 00001a00 0000a004 1
1 0 0 0 00001400 0000a005 1
1 1 0 0 00001fff 0000a006 1
1 0 0 0 00002000 0000a007 0
1 1 0 0 000013ff 0000a008 0
1 0 0 0 00001600 0000a009 1
1 1 0 0 00000000 0000a00a 0
1 0 0 0 00000000 0000a00b 0
1 1 0 0 00001800 0000a00c 1

//--- compile.f
bridge_pkg.sv
msg_parser.sv
bridge_manager.sv
msg_splitter.sv
out_arbiter.sv
bridge_top.sv
tb_clock_gen.sv
bridge_asserts.sv
bridge_tb.sv

//--- bridge_tb.sv
`timescale 1ns/1ps

module bridge_tb
    import bridge_pkg::*;
();

    localparam int max_cases = 64;
    localparam int timeout   = 200;

    logic             clk;
    logic             rst_n;
    logic [msg_w-1:0] in_msg_0, in_msg_1, out_msg_0, out_msg_1;
    logic             in_valid_0, in_valid_1, in_seen_0, in_seen_1;
    logic             out_valid_0, out_valid_1, out_ready_0, out_ready_1;

    int               c_mode[max_cases], c_side[max_cases], c_kind[max_cases];
    int               c_code[max_cases], c_exp[max_cases];
    logic [31:0]      c_addr[max_cases];
    logic [msg_w-1:0] c_word[max_cases];
    int               n_cases;
    logic [31:0]      m_lo, m_hi;
    logic             m_c0, m_c1;
    int               p_idx[2][max_cases];
    int               p_cnt[2];
    int               nxt[2][2];     // next expected entry per source and output.

    tb_clock_gen u_clk (.clk(clk));
    bridge_top uut (.*);

    task automatic check(input logic [msg_w-1:0] actual, input logic [msg_w-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Failure at %0t ns: %s", $time, why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    // output side predicted from the model state before the message is taken.
    function automatic int route(input int i);
        logic own_cl;
        logic oth_cl;
        own_cl = c_side[i] ? m_c1 : m_c0;
        oth_cl = c_side[i] ? m_c0 : m_c1;
        if (c_kind[i] == 1 && c_code[i] == 3 && own_cl) return c_side[i];
        if (c_kind[i] == 1 && c_code[i] == 3 && oth_cl) return 1 - c_side[i];
        if (c_kind[i] == 1 && c_code[i] == 2) return 1 - c_side[i];
        if (c_addr[i] >= m_lo && c_addr[i] < m_hi) return 1;
        return 0;
    endfunction

    task automatic model_accept(input int i);
        if (c_kind[i] == 1) begin
            case (c_code[i])
                0: if (c_side[i] == 1) m_c1 = 1'b0; else m_c0 = 1'b0;
                1: if (c_side[i] == 1 ? m_c0 : m_c1) m_hi = c_addr[i]; else m_lo = c_addr[i];
                2: if (!m_c0 && !m_c1) begin
                    if (c_side[i] == 1) m_c1 = 1'b1; else m_c0 = 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    task automatic drive_in(input int s, input logic v, input logic [msg_w-1:0] w);
        if (s == 1) begin
            in_valid_1 <= v;
            in_msg_1   <= w;
        end else begin
            in_valid_0 <= v;
            in_msg_0   <= w;
        end
    endtask

    function automatic logic seen_on(input int s);
        return (s == 1) ? (in_valid_1 && in_seen_1) : (in_valid_0 && in_seen_0);
    endfunction

    task automatic run_serial(input int i);
        int               cnt;
        int               got;
        logic [msg_w-1:0] w;
        check(c_exp[i], route(i), "expected side in case file");
        drive_in(c_side[i], 1'b1, c_word[i]);
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > timeout) abort_run("input message was never seen");
        end while (!seen_on(c_side[i]));
        model_accept(i);
        drive_in(c_side[i], 1'b0, '0);
        cnt = 0;
        got = -1;
        while (got < 0) begin
            @(posedge clk);
            cnt++;
            if (out_valid_0 && out_ready_0) begin
                got = 0;
                w   = out_msg_0;
            end else if (out_valid_1 && out_ready_1) begin
                got = 1;
                w   = out_msg_1;
            end else if (cnt > timeout) begin
                abort_run("accepted message never reached an output");
            end
        end
        check(got, c_exp[i], "output side");
        check(w, c_word[i], "message contents");
    endtask

    // each source keeps its own order per output, so only the two queue heads can match.
    task automatic match_out(input int o, input logic [msg_w-1:0] w);
        int   s;
        int   j;
        logic found;
        found = 1'b0;
        for (s = 0; s < 2 && !found; s++) begin
            j = nxt[s][o];
            while (j < p_cnt[s] && c_exp[p_idx[s][j]] != o) j++;
            if (j < p_cnt[s] && c_word[p_idx[s][j]][31:0] == w[31:0]) begin
                check(w, c_word[p_idx[s][j]], "paired message contents");
                nxt[s][o] = j + 1;
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Error at %0t ns: output %0d gave data %h out of order, twice or misrouted",
                     $time, o, w[31:0]);
            $display("Test failed");
            $fatal(1, "unexpected output message");
        end
    endtask

    task automatic run_paired(input int first, input int last);
        int ptr[2];
        int i;
        int s;
        int cnt;
        int got_total;
        int total;
        p_cnt[0] = 0;
        p_cnt[1] = 0;
        for (i = first; i <= last; i++) begin
            check(c_exp[i], route(i), "expected side in case file");
            s = c_side[i];
            p_idx[s][p_cnt[s]] = i;
            p_cnt[s]++;
        end
        for (s = 0; s < 4; s++) nxt[s / 2][s % 2] = 0;
        total = p_cnt[0] + p_cnt[1];
        ptr[0] = 0;
        ptr[1] = 0;
        got_total = 0;
        cnt = 0;
        while (got_total < total) begin
            @(posedge clk);
            cnt++;
            if (out_valid_0 && out_ready_0) begin
                match_out(0, out_msg_0);
                got_total++;
            end
            if (out_valid_1 && out_ready_1) begin
                match_out(1, out_msg_1);
                got_total++;
            end
            for (s = 0; s < 2; s++) begin
                if (seen_on(s)) ptr[s]++;
                if (ptr[s] < p_cnt[s]) drive_in(s, 1'b1, c_word[p_idx[s][ptr[s]]]);
                else                   drive_in(s, 1'b0, '0);
            end
            out_ready_0 <= ($urandom % 4) != 0;
            out_ready_1 <= ($urandom % 4) != 0;
            if (cnt > 10 * timeout) abort_run("paired traffic did not drain");
        end
        out_ready_0 <= 1'b1;
        out_ready_1 <= 1'b1;
        for (cnt = 0; cnt < 8; cnt++) begin
            @(posedge clk);
            if (out_valid_0 || out_valid_1) abort_run("extra message appeared on an output");
        end
    endtask

    initial begin
        int          fd;
        int          i;
        int          j;
        int          mo, sd, kd, cd, ex;
        logic [31:0] ad, dt;
        string       line;
        msg_u        u;
        rst_n       = 1'b0;
        in_msg_0    = '0;
        in_msg_1    = '0;
        in_valid_0  = 1'b0;
        in_valid_1  = 1'b0;
        out_ready_0 = 1'b0;
        out_ready_1 = 1'b0;
        m_lo        = '0;
        m_hi        = '0;
        m_c0        = 1'b0;
        m_c1        = 1'b0;
        n_cases     = 0;
        void'($urandom(32'h5bc4_10a5));

        fd = $fopen("bridge_cases.txt", "r");
        if (fd == 0) abort_run("cannot open bridge_cases.txt");
        while ($fgets(line, fd) && n_cases < max_cases) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h %h %h %h", mo, sd, kd, cd, ad, dt, ex) == 7) begin
                u = '0;
                if (kd == 0) begin
                    u.d.kind  = kind_data;
                    u.d.addr  = ad;
                    u.d.tag   = 5'($urandom);
                    u.d.bytes = 2'($urandom);
                    u.d.data  = dt;
                end else begin
                    u.c.kind = kind_ctrl;
                    u.c.code = ctrl_code_t'(cd);
                    u.c.addr = ad;
                    u.c.pad  = {4'h0, dt};    // keeps the unique value in the low bits.
                end
                c_mode[n_cases] = mo;
                c_side[n_cases] = sd;
                c_kind[n_cases] = kd;
                c_code[n_cases] = cd;
                c_addr[n_cases] = ad;
                c_exp[n_cases]  = ex;
                c_word[n_cases] = u;
                n_cases++;
            end
        end
        $fclose(fd);

        repeat (8) @(posedge clk);
        rst_n       <= 1'b1;
        out_ready_0 <= 1'b1;
        out_ready_1 <= 1'b1;
        @(posedge clk);

        i = 0;
        while (i < n_cases) begin
            if (c_mode[i] == 0) begin
                run_serial(i);
                i++;
            end else begin
                j = i;
                while (j + 1 < n_cases && c_mode[j + 1] == 1) j++;
                run_paired(i, j);
                i = j + 1;
            end
        end

        if (uut.u_asserts.fail_count != 0) begin
            $display("%0d handshake assertions failed", uut.u_asserts.fail_count);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- bridge_asserts.sv
`timescale 1ns/1ps

module bridge_asserts
    import bridge_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid_0,
    input logic             in_seen_0,
    input logic             in_valid_1,
    input logic             in_seen_1,
    input logic [msg_w-1:0] out_msg_0,
    input logic             out_valid_0,
    input logic             out_ready_0,
    input logic [msg_w-1:0] out_msg_1,
    input logic             out_valid_1,
    input logic             out_ready_1,
    input logic             req_00,
    input logic             req_01,
    input logic             req_10,
    input logic             req_11
);

    int fail_count = 0;    // read by the testbench at the end of the run.

    // a stalled output word must not change until it has been taken.
    hold_0: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_0 && !out_ready_0 |=> out_valid_0 && $stable(out_msg_0))
        else begin $error("output 0 changed while stalled"); fail_count++; end
    hold_1: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_1 && !out_ready_1 |=> out_valid_1 && $stable(out_msg_1))
        else begin $error("output 1 changed while stalled"); fail_count++; end

    seen_0: assert property (@(posedge clk) disable iff (!rst_n) in_seen_0 |-> in_valid_0)
        else begin $error("in_seen_0 high without in_valid_0"); fail_count++; end
    seen_1: assert property (@(posedge clk) disable iff (!rst_n) in_seen_1 |-> in_valid_1)
        else begin $error("in_seen_1 high without in_valid_1"); fail_count++; end

    one_req_0: assert property (@(posedge clk) disable iff (!rst_n) !(req_00 && req_01))
        else begin $error("splitter 0 requests both outputs"); fail_count++; end
    one_req_1: assert property (@(posedge clk) disable iff (!rst_n) !(req_10 && req_11))
        else begin $error("splitter 1 requests both outputs"); fail_count++; end

endmodule

bind bridge_top bridge_asserts u_asserts (.*);

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period.
    end

endmodule

//--- bridge_top.sv
`timescale 1ns/1ps

module bridge_top
    import bridge_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic [msg_w-1:0] in_msg_0,
    input  logic             in_valid_0,
    output logic             in_seen_0,
    input  logic [msg_w-1:0] in_msg_1,
    input  logic             in_valid_1,
    output logic             in_seen_1,

    output logic [msg_w-1:0] out_msg_0,
    output logic             out_valid_0,
    input  logic             out_ready_0,
    output logic [msg_w-1:0] out_msg_1,
    output logic             out_valid_1,
    input  logic             out_ready_1
);

    logic              rst_msg_0, enum_0, mreq_0, mresp_0;
    logic              rst_msg_1, enum_1, mreq_1, mresp_1;
    logic [addr_w-1:0] addr_0, addr_1;
    side_sel_t         sel_0, sel_1;
    logic              accept_0, accept_1;
    logic [msg_w-1:0]  held_0, held_1;
    logic              req_00, req_01, req_10, req_11;     // req_<source><output>.
    logic              gnt_00, gnt_01, gnt_10, gnt_11;

    msg_parser u_parser_0 (
        .msg(in_msg_0), .is_data(), .is_reset(rst_msg_0), .is_enumerate(enum_0),
        .is_mng_request(mreq_0), .is_mng_response(mresp_0), .addr(addr_0)
    );

    msg_parser u_parser_1 (
        .msg(in_msg_1), .is_data(), .is_reset(rst_msg_1), .is_enumerate(enum_1),
        .is_mng_request(mreq_1), .is_mng_response(mresp_1), .addr(addr_1)
    );

    bridge_manager u_manager (
        .clk(clk), .rst_n(rst_n),
        .accept_0(accept_0), .is_reset_0(rst_msg_0), .is_enumerate_0(enum_0),
        .is_mng_request_0(mreq_0), .is_mng_response_0(mresp_0), .addr_0(addr_0),
        .sel_0(sel_0),
        .accept_1(accept_1), .is_reset_1(rst_msg_1), .is_enumerate_1(enum_1),
        .is_mng_request_1(mreq_1), .is_mng_response_1(mresp_1), .addr_1(addr_1),
        .sel_1(sel_1)
    );

    msg_splitter u_split_0 (
        .clk(clk), .rst_n(rst_n), .in_msg(in_msg_0), .in_valid(in_valid_0), .sel(sel_0),
        .in_seen(in_seen_0), .accept(accept_0), .req_to_0(req_00), .req_to_1(req_01),
        .held_msg(held_0), .grant_from_0(gnt_00), .grant_from_1(gnt_01)
    );

    msg_splitter u_split_1 (
        .clk(clk), .rst_n(rst_n), .in_msg(in_msg_1), .in_valid(in_valid_1), .sel(sel_1),
        .in_seen(in_seen_1), .accept(accept_1), .req_to_0(req_10), .req_to_1(req_11),
        .held_msg(held_1), .grant_from_0(gnt_10), .grant_from_1(gnt_11)
    );

    // splitter 0 is requester a on both arbiters.
    out_arbiter u_arb_0 (
        .clk(clk), .rst_n(rst_n), .req_a(req_00), .req_b(req_10),
        .msg_a(held_0), .msg_b(held_1), .out_ready(out_ready_0),
        .grant_a(gnt_00), .grant_b(gnt_10), .out_msg(out_msg_0), .out_valid(out_valid_0)
    );

    out_arbiter u_arb_1 (
        .clk(clk), .rst_n(rst_n), .req_a(req_01), .req_b(req_11),
        .msg_a(held_0), .msg_b(held_1), .out_ready(out_ready_1),
        .grant_a(gnt_01), .grant_b(gnt_11), .out_msg(out_msg_1), .out_valid(out_valid_1)
    );

endmodule

//--- out_arbiter.sv
`timescale 1ns/1ps

module out_arbiter
    import bridge_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_a,
    input  logic             req_b,
    input  logic [msg_w-1:0] msg_a,
    input  logic [msg_w-1:0] msg_b,
    input  logic             out_ready,
    output logic             grant_a,
    output logic             grant_b,
    output logic [msg_w-1:0] out_msg,
    output logic             out_valid
);

    logic can_load;
    logic last_b;

    // the output register may take a word when empty or when it drains now.
    assign can_load = !out_valid || out_ready;

    // on a tie the requester that did not win last time goes first.
    assign grant_a = can_load && req_a && (!req_b || last_b);
    assign grant_b = can_load && req_b && (!req_a || !last_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            last_b    <= 1'b0;
        end else begin
            if (grant_a || grant_b) begin
                out_valid <= 1'b1;
                last_b    <= grant_b;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_a) begin
            out_msg <= msg_a;
        end else if (grant_b) begin
            out_msg <= msg_b;
        end
    end

endmodule

//--- msg_splitter.sv
`timescale 1ns/1ps

module msg_splitter
    import bridge_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [msg_w-1:0] in_msg,
    input  logic             in_valid,
    input  side_sel_t        sel,
    output logic             in_seen,
    output logic             accept,
    output logic             req_to_0,
    output logic             req_to_1,
    output logic [msg_w-1:0] held_msg,
    input  logic             grant_from_0,
    input  logic             grant_from_1
);

    logic      full;
    side_sel_t held_sel;
    logic      granted;

    // the buffer only takes a new word once it is empty again.
    assign in_seen = in_valid && !full;
    assign accept  = in_seen;

    assign req_to_0 = full && (held_sel == side_0);
    assign req_to_1 = full && (held_sel == side_1);

    // a grant from the arbiter we did not ask is ignored.
    assign granted = (req_to_0 && grant_from_0) || (req_to_1 && grant_from_1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full     <= 1'b0;
            held_sel <= side_0;
        end else if (accept) begin
            full     <= 1'b1;
            held_sel <= sel;         // choice made from the state before this edge.
        end else if (granted) begin
            full     <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_msg <= in_msg;
        end
    end

endmodule

//--- bridge_manager.sv
`timescale 1ns/1ps

module bridge_manager
    import bridge_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              accept_0,
    input  logic              is_reset_0,
    input  logic              is_enumerate_0,
    input  logic              is_mng_request_0,
    input  logic              is_mng_response_0,
    input  logic [addr_w-1:0] addr_0,
    output side_sel_t         sel_0,

    input  logic              accept_1,
    input  logic              is_reset_1,
    input  logic              is_enumerate_1,
    input  logic              is_mng_request_1,
    input  logic              is_mng_response_1,
    input  logic [addr_w-1:0] addr_1,
    output side_sel_t         sel_1
);

    logic [addr_w-1:0] lo_addr;
    logic [addr_w-1:0] hi_addr;
    logic              side0_claimed;
    logic              side1_claimed;
    logic              claim_0;
    logic              claim_1;

    // routing for one input, with own naming the side the message came in on.
    function automatic side_sel_t pick_side(
        input logic              resp,
        input logic              req,
        input logic              own_claimed,
        input logic              other_claimed,
        input side_sel_t         own,
        input logic [addr_w-1:0] a,
        input logic [addr_w-1:0] lo,
        input logic [addr_w-1:0] hi
    );
        side_sel_t other;
        other = (own == side_0) ? side_1 : side_0;
        if (resp && own_claimed) begin
            return own;
        end else if (resp && other_claimed) begin
            return other;
        end else if (req) begin
            return other;               // requests always cross over.
        end else if (a < lo || a >= hi) begin
            return side_0;
        end
        return side_1;
    endfunction

    // a request only claims while nobody holds the role; side 0 wins a tie.
    assign claim_0 = accept_0 && is_mng_request_0 && !side0_claimed && !side1_claimed;
    assign claim_1 = accept_1 && is_mng_request_1 && !side0_claimed && !side1_claimed &&
                     !claim_0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lo_addr       <= '0;
            hi_addr       <= '0;
            side0_claimed <= 1'b0;
            side1_claimed <= 1'b0;
        end else begin
            if (claim_0) begin
                side0_claimed <= 1'b1;
            end else if (accept_0 && is_reset_0) begin
                side0_claimed <= 1'b0;
            end
            if (claim_1) begin
                side1_claimed <= 1'b1;
            end else if (accept_1 && is_reset_1) begin
                side1_claimed <= 1'b0;
            end

            // enumeration from the far side of the manager sets the upper bound.
            if (accept_0 && is_enumerate_0) begin
                if (side1_claimed) hi_addr <= addr_0;
                else               lo_addr <= addr_0;
            end
            if (accept_1 && is_enumerate_1) begin
                if (side0_claimed) hi_addr <= addr_1;
                else               lo_addr <= addr_1;
            end
        end
    end

    assign sel_0 = pick_side(is_mng_response_0, is_mng_request_0, side0_claimed,
                             side1_claimed, side_0, addr_0, lo_addr, hi_addr);
    assign sel_1 = pick_side(is_mng_response_1, is_mng_request_1, side1_claimed,
                             side0_claimed, side_1, addr_1, lo_addr, hi_addr);

endmodule

//--- msg_parser.sv
`timescale 1ns/1ps

module msg_parser
    import bridge_pkg::*;
(
    input  msg_u              msg,
    output logic              is_data,
    output logic              is_reset,
    output logic              is_enumerate,
    output logic              is_mng_request,
    output logic              is_mng_response,
    output logic [addr_w-1:0] addr
);

    logic is_ctrl;

    always_comb begin
        is_data = (msg.d.kind == kind_data);
        is_ctrl = (msg.c.kind == kind_ctrl);

        is_reset        = is_ctrl && (msg.c.code == code_reset);
        is_enumerate    = is_ctrl && (msg.c.code == code_enumerate);
        is_mng_request  = is_ctrl && (msg.c.code == code_mng_request);
        is_mng_response = is_ctrl && (msg.c.code == code_mng_response);

        // control words carry their address further down the word.
        if (is_data) begin
            addr = msg.d.addr;
        end else begin
            addr = msg.c.addr;
        end
    end

endmodule

//--- bridge_pkg.sv
package bridge_pkg;

    localparam int addr_w  = 32;
    localparam int data_w  = 32;
    localparam int tag_w   = 5;
    localparam int bytes_w = 2;
    localparam int kind_w  = 2;
    localparam int code_w  = 3;

    // one ring message is 73 bits wide.
    localparam int msg_w = kind_w + addr_w + tag_w + bytes_w + data_w;

    // the control view fills the rest of the word with padding.
    localparam int pad_w = msg_w - kind_w - code_w - addr_w;

    typedef enum logic [kind_w-1:0] {
        kind_data = 2'd0,
        kind_ctrl = 2'd1
    } msg_kind_t;

    typedef enum logic [code_w-1:0] {
        code_reset        = 3'd0,
        code_enumerate    = 3'd1,
        code_mng_request  = 3'd2,
        code_mng_response = 3'd3
    } ctrl_code_t;

    typedef struct packed {
        msg_kind_t            kind;
        logic [addr_w-1:0]    addr;
        logic [tag_w-1:0]     tag;
        logic [bytes_w-1:0]   bytes;
        logic [data_w-1:0]    data;
    } msg_data_t;

    typedef struct packed {
        msg_kind_t            kind;
        ctrl_code_t           code;
        logic [addr_w-1:0]    addr;
        logic [pad_w-1:0]     pad;
    } msg_ctrl_t;

    // both views keep the kind in the top two bits, so either one can be
    // used to find out which view applies.
    typedef union packed {
        msg_data_t d;
        msg_ctrl_t c;
    } msg_u;

    typedef enum logic {
        side_0 = 1'b0,
        side_1 = 1'b1
    } side_sel_t;

endpackage
